// File: files.f
logic/link_pkg.sv
logic/link_config_regs.sv
logic/link_online_sync.sv
logic/link_field_pack.sv
logic/link_lane_map.sv
logic/lpif_link_top.sv
test/link_checker.sv
test/tb_lpif_link.sv

// File: Makefile
# Verilator build and run of the link adapter testbench

TOP = tb_lpif_link
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_lpif_link.sv
/*
  Testbench for the two-lane link adapter. Writes the delay registers,
  loops the PHY lanes back through a strobe-kill mux and applies a
  stimulus table. link_checker does the comparing. Run with make test.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_link;
  import link_pkg::*;

  localparam int ROWS  = 24;
  localparam int DLY_X = 3;
  localparam int DLY_Y = 2;
  localparam int DLY_Z = 1;
  // Table, delays and slack for reset, config and drain
  localparam int WATCHDOG_CYCLES = ROWS + DLY_X + DLY_Y + DLY_Z + 50;

  logic                clk_wr;
  logic                rst;
  logic                tx_online;
  logic                rx_online;
  logic                cfg_wr;
  logic [1:0]          cfg_addr;
  delay_t              cfg_wdata;
  lane_t               tx_phy0;
  lane_t               tx_phy1;
  lane_t               rx_phy0;
  lane_t               rx_phy1;
  logic [STATE_W-1:0]  dstrm_state;
  logic [PROTID_W-1:0] dstrm_protid;
  logic [DATA_W-1:0]   dstrm_data;
  logic                dstrm_dvalid;
  logic [CRC_W-1:0]    dstrm_crc;
  logic                dstrm_crc_valid;
  logic                dstrm_valid;
  logic [STATE_W-1:0]  ustrm_state;
  logic [PROTID_W-1:0] ustrm_protid;
  logic [DATA_W-1:0]   ustrm_data;
  logic                ustrm_dvalid;
  logic [CRC_W-1:0]    ustrm_crc;
  logic                ustrm_crc_valid;
  logic                ustrm_valid;
  status_t             tx_downstream_debug_status;
  status_t             rx_upstream_debug_status;
  logic                strobe_kill;
  logic                done;
  logic                checks_done;
  int                  err_count;
  integer              seed;

  // One stimulus table row per clock
  logic [STATE_W-1:0]  tbl_state  [ROWS];
  logic [PROTID_W-1:0] tbl_protid [ROWS];
  logic [DATA_W-1:0]   tbl_data   [ROWS];
  logic                tbl_dvalid [ROWS];
  logic [CRC_W-1:0]    tbl_crc    [ROWS];
  logic                tbl_crcv   [ROWS];
  logic                tbl_valid  [ROWS];
  logic                tbl_kill   [ROWS];

  always #10 clk_wr = ~clk_wr;

  // PHY loopback with a lane 0 strobe kill
  assign rx_phy0 = {tx_phy0[LANE_W-1:1], tx_phy0[STB_POS] & ~strobe_kill};
  assign rx_phy1 = tx_phy1;

  lpif_link_top i_lpif_link_top (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .cfg_wr                     (cfg_wr),
    .cfg_addr                   (cfg_addr),
    .cfg_wdata                  (cfg_wdata),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  link_checker #(.TX_DELAY(DLY_Y + DLY_Z)) i_link_checker (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .strobe_kill                (strobe_kill),
    .done                       (done),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status),
    .checks_done                (checks_done),
    .err_count                  (err_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic build_table();
    logic [31:0] r;
    for (int i = 0; i < ROWS; i++) begin
      r = $random(seed);
      tbl_state[i]  = r[3:0];
      tbl_protid[i] = r[5:4];
      tbl_crc[i]    = r[9:6];
      tbl_dvalid[i] = r[10];
      tbl_crcv[i]   = r[11];
      // Leading rows all valid, so RX going online shows on ustrm_valid
      tbl_valid[i]  = (i < 14) || (i % 3 == 0);
      tbl_data[i]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      // Row 5 kill falls inside RX strobe qualification
      tbl_kill[i]   = (i == 5) || (i == 16) || (i == 20);
    end
  endtask

  task automatic write_cfg(input logic [1:0] addr, input delay_t data);
    @(posedge clk_wr);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
  endtask

  task automatic drive_row(input int i);
    dstrm_state     <= tbl_state[i];
    dstrm_protid    <= tbl_protid[i];
    dstrm_data      <= tbl_data[i];
    dstrm_dvalid    <= tbl_dvalid[i];
    dstrm_crc       <= tbl_crc[i];
    dstrm_crc_valid <= tbl_crcv[i];
    dstrm_valid     <= tbl_valid[i];
    strobe_kill     <= tbl_kill[i];
  endtask

  task automatic drive_idle();
    dstrm_state     <= '0;
    dstrm_protid    <= '0;
    dstrm_data      <= '0;
    dstrm_dvalid    <= 1'b0;
    dstrm_crc       <= '0;
    dstrm_crc_valid <= 1'b0;
    dstrm_valid     <= 1'b0;
    strobe_kill     <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed            = 90;
    clk_wr          = 1'b0;
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    cfg_wr          = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    strobe_kill     = 1'b0;
    done            = 1'b0;
    build_table();
    repeat (2) @(posedge clk_wr);
    rst <= 1'b0;
    write_cfg(CFG_ADDR_X, delay_t'(DLY_X));
    write_cfg(CFG_ADDR_Y, delay_t'(DLY_Y));
    write_cfg(CFG_ADDR_Z, delay_t'(DLY_Z));
    @(posedge clk_wr);
    cfg_wr    <= 1'b0;
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    for (int i = 0; i < ROWS; i++) begin
      @(posedge clk_wr);
      drive_row(i);
    end
    @(posedge clk_wr);
    drive_idle();
    // Loopback latency of two plus the miss counter stage
    repeat (4) @(posedge clk_wr);
    done <= 1'b1;
    while (!checks_done) @(posedge clk_wr);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_wr);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/link_checker.sv
/*
  Watches the link adapter ports in the loopback testbench. Predicts the
  upstream fields from a two-deep downstream history, checks the TX lanes,
  marker and both status words. The top reads the error count at the end.
*/
`timescale 1ns/1ps
`default_nettype none

module link_checker #(
  parameter int TX_DELAY = 3
) (
  input  logic                          clk_wr,
  input  logic                          rst,
  input  logic                          tx_online,
  input  logic                          strobe_kill,
  input  logic                          done,
  input  link_pkg::lane_t               tx_phy0,
  input  link_pkg::lane_t               tx_phy1,
  input  logic [link_pkg::STATE_W-1:0]  dstrm_state,
  input  logic [link_pkg::PROTID_W-1:0] dstrm_protid,
  input  logic [link_pkg::DATA_W-1:0]   dstrm_data,
  input  logic                          dstrm_dvalid,
  input  logic [link_pkg::CRC_W-1:0]    dstrm_crc,
  input  logic                          dstrm_crc_valid,
  input  logic                          dstrm_valid,
  input  logic [link_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [link_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [link_pkg::DATA_W-1:0]   ustrm_data,
  input  logic                          ustrm_dvalid,
  input  logic [link_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                          ustrm_crc_valid,
  input  logic                          ustrm_valid,
  input  link_pkg::status_t             tx_downstream_debug_status,
  input  link_pkg::status_t             rx_upstream_debug_status,
  output logic                          checks_done,
  output int                            err_count
);
  import link_pkg::*;

  // Compare word with the valid bit on top and data at the bottom
  localparam int V_BIT = 140;

  logic [140:0] dn_word;
  logic [140:0] up_word;
  logic [140:0] hist1;
  logic [140:0] hist2;
  logic [1:0]   marker;
  logic [1:0]   exp_marker;
  logic         tx_started;
  logic         rx_seen_online;
  int           tx_cycles;
  int           exp_tx_words;
  int           exp_misses;
  int           check_count;

  task automatic flag_mismatch(input string msg);
    err_count = err_count + 1;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic fail_run(input string msg);
    err_count = err_count + 1;
    $display("%s", msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // TX lanes, marker and word count

  task automatic check_tx_lanes();
    check_count = check_count + 1;
    // One edge to see tx_online, the delay, then one edge into the lanes
    if (!tx_started && tx_phy0[STB_POS]) begin
      tx_started = 1'b1;
      if (tx_cycles != TX_DELAY + 2) begin
        flag_mismatch($sformatf("TX online after %0d cycles, expected %0d",
                                tx_cycles, TX_DELAY + 2));
      end
    end
    if (!tx_started) begin
      if (tx_phy0 != '0 || tx_phy1 != '0) begin
        flag_mismatch("tx_phy not all zero while TX offline");
      end
      if (tx_online && tx_cycles == TX_DELAY + 2) begin
        flag_mismatch($sformatf("TX still offline after %0d cycles", tx_cycles));
      end
    end else begin
      if (!tx_phy0[STB_POS]) begin
        flag_mismatch("strobe low on tx_phy0 while online");
      end
      if (marker != exp_marker) begin
        flag_mismatch($sformatf("marker %0d, expected %0d", marker, exp_marker));
      end
      exp_marker = exp_marker + 2'd1;
      // Lanes now carry the word applied one cycle back
      if (hist1[V_BIT]) begin
        exp_tx_words = exp_tx_words + 1;
      end
    end
    if (tx_downstream_debug_status != exp_tx_words) begin
      flag_mismatch($sformatf("TX status %0d, expected %0d",
                              tx_downstream_debug_status, exp_tx_words));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Upstream fields and strobe misses

  task automatic check_upstream();
    check_count = check_count + 1;
    if (!rx_seen_online && ustrm_valid) begin
      rx_seen_online = 1'b1;
    end
    if (rx_seen_online) begin
      if (up_word != hist2) begin
        flag_mismatch($sformatf("upstream %h, expected %h", up_word, hist2));
      end
      if (strobe_kill) begin
        exp_misses = exp_misses + 1;
      end
    end else begin
      if (ustrm_dvalid || ustrm_crc_valid) begin
        flag_mismatch("upstream valids high before RX online");
      end
      if (rx_upstream_debug_status != 0) begin
        flag_mismatch("RX status not zero before RX online");
      end
    end
  endtask

  task automatic summarize_run();
    check_count = check_count + 1;
    if (!tx_started) begin
      fail_run("The transmitter never went online");
    end
    if (!rx_seen_online) begin
      fail_run("The receiver never came online");
    end
    if (exp_misses == 0) begin
      fail_run("No strobe was killed while the receiver was online");
    end
    if (rx_upstream_debug_status != exp_misses) begin
      flag_mismatch($sformatf("RX status %0d, expected %0d",
                              rx_upstream_debug_status, exp_misses));
    end
    $display("Checker summary: %0d checks, %0d errors", check_count, err_count);
    checks_done = 1'b1;
  endtask

  // Falling edge sampling sits between the drive edges
  always @(negedge clk_wr) begin
    dn_word = {dstrm_valid, dstrm_dvalid, dstrm_crc_valid, dstrm_state,
               dstrm_protid, dstrm_crc, dstrm_data};
    up_word = {ustrm_valid, ustrm_dvalid, ustrm_crc_valid, ustrm_state,
               ustrm_protid, ustrm_crc, ustrm_data};
    marker  = {tx_phy1[MRK1_POS], tx_phy0[MRK0_POS]};
    if (rst) begin
      tx_cycles      = 0;
      tx_started     = 1'b0;
      rx_seen_online = 1'b0;
      exp_marker     = '0;
      exp_tx_words   = 0;
      exp_misses     = 0;
      check_count    = 0;
      err_count      = 0;
      checks_done    = 1'b0;
    end else begin
      check_tx_lanes();
      check_upstream();
      if (tx_online) begin
        tx_cycles = tx_cycles + 1;
      end
      if (done && !checks_done) begin
        summarize_run();
      end
    end
    hist2 = hist1;
    hist1 = dn_word;
  end

endmodule

`default_nettype wire

// File: logic/lpif_link_top.sv
/*
  Two-lane link adapter top. Joins the config registers, online
  sequencing, field packer and lane mapper. Single clock clk_wr.
*/
`timescale 1ns/1ps
`default_nettype none

module lpif_link_top (
  input  logic                          clk_wr,
  input  logic                          rst,
  input  logic                          tx_online,
  input  logic                          rx_online,

  // Configuration write port
  input  logic                          cfg_wr,
  input  logic [1:0]                    cfg_addr,
  input  link_pkg::delay_t              cfg_wdata,

  // PHY lanes
  output link_pkg::lane_t               tx_phy0,
  output link_pkg::lane_t               tx_phy1,
  input  link_pkg::lane_t               rx_phy0,
  input  link_pkg::lane_t               rx_phy1,

  // Downstream channel
  input  logic [link_pkg::STATE_W-1:0]  dstrm_state,
  input  logic [link_pkg::PROTID_W-1:0] dstrm_protid,
  input  logic [link_pkg::DATA_W-1:0]   dstrm_data,
  input  logic                          dstrm_dvalid,
  input  logic [link_pkg::CRC_W-1:0]    dstrm_crc,
  input  logic                          dstrm_crc_valid,
  input  logic                          dstrm_valid,

  // Upstream channel
  output logic [link_pkg::STATE_W-1:0]  ustrm_state,
  output logic [link_pkg::PROTID_W-1:0] ustrm_protid,
  output logic [link_pkg::DATA_W-1:0]   ustrm_data,
  output logic                          ustrm_dvalid,
  output logic [link_pkg::CRC_W-1:0]    ustrm_crc,
  output logic                          ustrm_crc_valid,
  output logic                          ustrm_valid,

  // Debug status
  output link_pkg::status_t             tx_downstream_debug_status,
  output link_pkg::status_t             rx_upstream_debug_status
);
  import link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect

  delay_t  delay_x;
  delay_t  delay_y;
  delay_t  delay_z;
  logic    tx_online_delay;
  logic    rx_online_delay;
  marker_t tx_marker;
  logic    rx_strobe;
  flit_t   tx_flit;
  flit_t   rx_flit;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration and sequencing

  link_config_regs i_link_config_regs (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .delay_x   (delay_x),
    .delay_y   (delay_y),
    .delay_z   (delay_z)
  );

  link_online_sync i_link_online_sync (
    .clk_wr                   (clk_wr),
    .rst                      (rst),
    .tx_online                (tx_online),
    .rx_online                (rx_online),
    .delay_x                  (delay_x),
    .delay_y                  (delay_y),
    .delay_z                  (delay_z),
    .rx_strobe                (rx_strobe),
    .tx_online_delay          (tx_online_delay),
    .tx_marker                (tx_marker),
    .rx_online_delay          (rx_online_delay),
    .rx_upstream_debug_status (rx_upstream_debug_status)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path

  // User side fields to and from the flit word
  link_field_pack i_link_field_pack (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .rx_online_delay (rx_online_delay)
  );

  // Flit to PHY lanes and back
  link_lane_map i_link_lane_map (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_flit                    (tx_flit),
    .tx_online_delay            (tx_online_delay),
    .tx_marker                  (tx_marker),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_flit                    (rx_flit),
    .rx_strobe                  (rx_strobe),
    .tx_downstream_debug_status (tx_downstream_debug_status)
  );

endmodule

`default_nettype wire

// File: logic/link_lane_map.sv
/*
  Lane mapper. Registers the TX flit with strobe and marker onto two
  80-bit PHY lanes, captures the RX lanes and rebuilds the flit.
  Also counts transmitted words that carry dstrm_valid.
*/
`timescale 1ns/1ps
`default_nettype none

module link_lane_map (
  input  logic               clk_wr,
  input  logic               rst,
  input  link_pkg::flit_t    tx_flit,
  input  logic               tx_online_delay,
  input  link_pkg::marker_t  tx_marker,
  output link_pkg::lane_t    tx_phy0,
  output link_pkg::lane_t    tx_phy1,
  input  link_pkg::lane_t    rx_phy0,
  input  link_pkg::lane_t    rx_phy1,
  output link_pkg::flit_t    rx_flit,
  output logic               rx_strobe,
  output link_pkg::status_t  tx_downstream_debug_status
);
  import link_pkg::*;

  lane_t tx_lane0_nxt;
  lane_t tx_lane1_nxt;
  lane_t rx_lane0_q;
  lane_t rx_lane1_q;

  ////////////////////////////////////////////////////////////////////////////
  // TX lane build

  always_comb begin
    // Offline, both lanes stay all zero
    tx_lane0_nxt = '0;
    tx_lane1_nxt = '0;
    if (tx_online_delay) begin
      // Lane 0 strobe, flit bits 0 to 77, marker bit 0
      tx_lane0_nxt[STB_POS]                          = 1'b1;
      tx_lane0_nxt[STB_POS+1 +: LANE0_DATA_BITS]     = tx_flit[0 +: LANE0_DATA_BITS];
      tx_lane0_nxt[MRK0_POS]                         = tx_marker[0];
      // Lane 1 flit bits 78 to 140, marker bit 1
      tx_lane1_nxt[0 +: LANE1_DATA_BITS]             =
        tx_flit[LANE0_DATA_BITS +: LANE1_DATA_BITS];
      tx_lane1_nxt[MRK1_POS]                         = tx_marker[1];
      // Lane 1 bits 63 to 78 left at zero
    end
  end

  // One cycle from the dstrm fields to the PHY
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= tx_lane0_nxt;
      tx_phy1 <= tx_lane1_nxt;
    end
  end

  // Words sent with the valid bit set, wraps at 32 bits
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_downstream_debug_status <= '0;
    end else if (tx_online_delay && tx_flit[VALID_POS]) begin
      tx_downstream_debug_status <= tx_downstream_debug_status + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RX lane capture

  // Sampled every cycle
  // Cleared on reset so the strobe starts low
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_lane0_q <= '0;
      rx_lane1_q <= '0;
    end else begin
      rx_lane0_q <= rx_phy0;
      rx_lane1_q <= rx_phy1;
    end
  end

  assign rx_strobe = rx_lane0_q[STB_POS];

  // Reassembly, lane 1 holds the upper flit bits
  assign rx_flit = {rx_lane1_q[0 +: LANE1_DATA_BITS],
                    rx_lane0_q[STB_POS+1 +: LANE0_DATA_BITS]};

  // RX marker bits are carried but not checked here

endmodule

`default_nettype wire

// File: logic/link_field_pack.sv
/*
  Packs the downstream fields into one flit word and splits the received
  flit back into upstream fields. Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module link_field_pack (
  // Downstream fields
  input  logic [link_pkg::STATE_W-1:0]  dstrm_state,
  input  logic [link_pkg::PROTID_W-1:0] dstrm_protid,
  input  logic [link_pkg::DATA_W-1:0]   dstrm_data,
  input  logic                          dstrm_dvalid,
  input  logic [link_pkg::CRC_W-1:0]    dstrm_crc,
  input  logic                          dstrm_crc_valid,
  input  logic                          dstrm_valid,
  // Upstream fields
  output logic [link_pkg::STATE_W-1:0]  ustrm_state,
  output logic [link_pkg::PROTID_W-1:0] ustrm_protid,
  output logic [link_pkg::DATA_W-1:0]   ustrm_data,
  output logic                          ustrm_dvalid,
  output logic [link_pkg::CRC_W-1:0]    ustrm_crc,
  output logic                          ustrm_crc_valid,
  output logic                          ustrm_valid,
  // Link side
  output link_pkg::flit_t               tx_flit,
  input  link_pkg::flit_t               rx_flit,
  input  logic                          rx_online_delay
);
  import link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // TX pack

  // Every flit bit is covered by a field
  assign tx_flit[VALID_POS]               = dstrm_valid;
  assign tx_flit[CRCV_POS]                = dstrm_crc_valid;
  assign tx_flit[CRC_POS    +: CRC_W]     = dstrm_crc;
  assign tx_flit[DVALID_POS]              = dstrm_dvalid;
  assign tx_flit[DATA_POS   +: DATA_W]    = dstrm_data;
  assign tx_flit[PROTID_POS +: PROTID_W]  = dstrm_protid;
  assign tx_flit[STATE_POS  +: STATE_W]   = dstrm_state;

  ////////////////////////////////////////////////////////////////////////////
  // RX unpack

  assign ustrm_state  = rx_flit[STATE_POS  +: STATE_W];
  assign ustrm_protid = rx_flit[PROTID_POS +: PROTID_W];
  assign ustrm_data   = rx_flit[DATA_POS   +: DATA_W];
  assign ustrm_crc    = rx_flit[CRC_POS    +: CRC_W];

  // Valids held low until the receiver has qualified the strobe
  assign ustrm_valid     = rx_flit[VALID_POS]  & rx_online_delay;
  assign ustrm_crc_valid = rx_flit[CRCV_POS]   & rx_online_delay;
  assign ustrm_dvalid    = rx_flit[DVALID_POS] & rx_online_delay;

endmodule

`default_nettype wire

// File: logic/link_online_sync.sv
/*
  Online sequencing. Holds TX quiet for delay_y plus delay_z cycles after
  tx_online, qualifies the RX strobe for delay_x cycles after rx_online,
  runs the lane marker counter and counts strobe misses once online.
*/
`timescale 1ns/1ps
`default_nettype none

module link_online_sync (
  input  logic               clk_wr,
  input  logic               rst,
  input  logic               tx_online,
  input  logic               rx_online,
  input  link_pkg::delay_t   delay_x,
  input  link_pkg::delay_t   delay_y,
  input  link_pkg::delay_t   delay_z,
  input  logic               rx_strobe,
  output logic               tx_online_delay,
  output link_pkg::marker_t  tx_marker,
  output logic               rx_online_delay,
  output link_pkg::status_t  rx_upstream_debug_status
);
  import link_pkg::*;

  tx_state_t   tx_state;
  logic [16:0] tx_total;
  logic [16:0] tx_cnt;
  logic [16:0] tx_cnt_nxt;
  rx_state_t   rx_state;
  delay_t      rx_cnt;
  logic [16:0] rx_cnt_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // TX side

  // Extra bit keeps y + z from wrapping
  assign tx_total   = {1'b0, delay_y} + {1'b0, delay_z};
  assign tx_cnt_nxt = tx_cnt + 17'd1;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          tx_cnt <= '0;
          // Zero delay skips the wait state
          if (tx_online && (tx_total == '0)) begin
            tx_state <= TX_ONLINE;
          end else if (tx_online) begin
            tx_state <= TX_WAIT;
          end
        end
        TX_WAIT: begin
          if (!tx_online) begin
            tx_state <= TX_IDLE;
          end else if (tx_cnt_nxt >= tx_total) begin
            tx_state <= TX_ONLINE;
          end else begin
            tx_cnt <= tx_cnt_nxt;
          end
        end
        TX_ONLINE: begin
          if (!tx_online) begin
            tx_state <= TX_IDLE;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  assign tx_online_delay = (tx_state == TX_ONLINE);

  // Marker restarts at 0 for the first online word
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      tx_marker <= '0;
    end else begin
      tx_marker <= tx_marker + 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RX side

  assign rx_cnt_nxt = {1'b0, rx_cnt} + 17'd1;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_state                 <= RX_IDLE;
      rx_cnt                   <= '0;
      rx_upstream_debug_status <= '0;
    end else begin
      case (rx_state)
        RX_IDLE: begin
          rx_cnt <= '0;
          if (rx_online) begin
            rx_state <= RX_QUAL;
          end
        end
        RX_QUAL: begin
          if (!rx_online) begin
            rx_state <= RX_IDLE;
          end else if (!rx_strobe) begin
            // Gap in the strobe, start over
            rx_cnt <= '0;
          end else if (rx_cnt_nxt >= {1'b0, delay_x}) begin
            rx_state <= RX_ONLINE;
          end else begin
            rx_cnt <= rx_cnt_nxt[15:0];
          end
        end
        RX_ONLINE: begin
          if (!rx_online) begin
            rx_state <= RX_IDLE;
          end else if (!rx_strobe) begin
            rx_upstream_debug_status <= rx_upstream_debug_status + 32'd1;
          end
        end
        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  assign rx_online_delay = (rx_state == RX_ONLINE);

endmodule

`default_nettype wire

// File: logic/link_config_regs.sv
/*
  Delay registers for the online sequencing block. Loaded by a
  single-cycle write strobe, no back-pressure, no read-back.
*/
`timescale 1ns/1ps
`default_nettype none

module link_config_regs (
  input  logic             clk_wr,
  input  logic             rst,
  input  logic             cfg_wr,
  input  logic [1:0]       cfg_addr,
  input  link_pkg::delay_t cfg_wdata,
  output link_pkg::delay_t delay_x,
  output link_pkg::delay_t delay_y,
  output link_pkg::delay_t delay_z
);
  import link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Register file

  // RX strobe qualification length
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      delay_x <= DELAY_X_RST;
    end else if (cfg_wr && (cfg_addr == CFG_ADDR_X)) begin
      delay_x <= cfg_wdata;
    end
  end

  // First part of the TX online delay
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      delay_y <= DELAY_Y_RST;
    end else if (cfg_wr && (cfg_addr == CFG_ADDR_Y)) begin
      delay_y <= cfg_wdata;
    end
  end

  // Second part of the TX online delay
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      delay_z <= DELAY_Z_RST;
    end else if (cfg_wr && (cfg_addr == CFG_ADDR_Z)) begin
      delay_z <= cfg_wdata;
    end
  end

  // Address 3 decodes to nothing, write dropped

  // Register file
  ////////////////////////////////////////////////////////////////////////////

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
/*
  Shared widths, types, lane bit positions and configuration constants
  for the two-lane link adapter. Every RTL file imports from here.
*/
`default_nettype none

package link_pkg;

  // Field widths of the flit
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 128;
  localparam int CRC_W    = 4;
  localparam int FLIT_W   = 141;
  localparam int LANE_W   = 80;

  typedef logic [FLIT_W-1:0] flit_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [15:0]       delay_t;
  typedef logic [31:0]       status_t;
  typedef logic [1:0]        marker_t;

  // Field offsets inside the flit, LSB first
  localparam int VALID_POS  = 0;
  localparam int CRCV_POS   = 1;
  localparam int CRC_POS    = 2;
  localparam int DVALID_POS = 6;
  localparam int DATA_POS   = 7;
  localparam int PROTID_POS = 135;
  localparam int STATE_POS  = 137;

  // Lane bit positions
  localparam int STB_POS         = 0;
  localparam int MRK0_POS        = 79;
  localparam int MRK1_POS        = 79;
  localparam int LANE0_DATA_BITS = 78;
  // Remainder of the flit, lane 1 bits 0 to 62
  localparam int LANE1_DATA_BITS = FLIT_W - LANE0_DATA_BITS;

  // Configuration map
  localparam logic [1:0] CFG_ADDR_X = 2'd0;
  localparam logic [1:0] CFG_ADDR_Y = 2'd1;
  localparam logic [1:0] CFG_ADDR_Z = 2'd2;

  localparam delay_t DELAY_X_RST = 16'd4;
  localparam delay_t DELAY_Y_RST = 16'd2;
  localparam delay_t DELAY_Z_RST = 16'd2;

  typedef enum logic [1:0] {RX_IDLE, RX_QUAL, RX_ONLINE} rx_state_t;
  typedef enum logic [1:0] {TX_IDLE, TX_WAIT, TX_ONLINE} tx_state_t;

endpackage

`default_nettype wire
